/* source/video_defines.svh */
//####################################################################
// video generator constants: raster timing, framebuffer geometry,
// scale factor and border colour
//####################################################################
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// horizontal raster, in pixels
`define H_ACTIVE 72
`define H_FP 4
`define H_SYNC 8
`define H_BP 4
`define H_TOTAL (`H_ACTIVE + `H_FP + `H_SYNC + `H_BP)

// vertical raster, in lines
`define V_ACTIVE 52
`define V_FP 2
`define V_SYNC 2
`define V_BP 2
`define V_TOTAL (`V_ACTIVE + `V_FP + `V_SYNC + `V_BP)

// framebuffer geometry, one colour index per pixel
`define FB_WIDTH 16
`define FB_HEIGHT 12
`define FB_SCALE 4
`define FB_PIXELS (`FB_WIDTH * `FB_HEIGHT)
`define FB_ADDRW 8

// scaled picture in the top-left of the raster
`define PIC_WIDTH (`FB_WIDTH * `FB_SCALE)
`define PIC_HEIGHT (`FB_HEIGHT * `FB_SCALE)

// active area outside the picture
`define BORDER_COLOUR 12'h137

`endif

/* source/video_pkg.sv */
//####################################################################
// video types: colour index, rgb word and coordinates
//####################################################################
`include "video_defines.svh"

package video_pkg;

    // palette index, one framebuffer pixel
    typedef logic [3:0] cidx_t;

    // 4:4:4 colour, r in the top nibble
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    typedef logic [15:0] coord_t;  // unsigned raster position

    // framebuffer word address
    typedef logic [`FB_ADDRW-1:0] fb_addr_t;

    typedef logic [3:0] lb_addr_t;  // column within one stored row

endpackage

/* source/video_timing_if.sv */
//####################################################################
// raster position and sync bundle, plus the line-buffer fill bundle
//####################################################################
`timescale 1ns/1ns

interface video_timing_if;
    video_pkg::coord_t sx;  // 0..H_TOTAL-1
    video_pkg::coord_t sy;  // 0..V_TOTAL-1
    logic hsync;            // active low
    logic vsync;            // active low
    logic de;               // active area
    logic line;             // pulse at sx 0
    logic frame;            // pulse at sx 0, sy 0

    modport source (output sx, sy, hsync, vsync, de, line, frame);
    modport sink (input sx, sy, hsync, vsync, de, line, frame);
endinterface

interface line_fill_if;
    logic we;                     // one word per cycle during a fetch
    video_pkg::lb_addr_t waddr;
    logic wbank;                  // bank not on screen
    video_pkg::cidx_t wdata;
    logic show_bank;              // bank read out this line

    modport filler (output we, waddr, wbank, wdata, show_bank);
    modport store (input we, waddr, wbank, wdata, show_bank);
endinterface

/* source/sdp_ram.sv */
//####################################################################
// simple dual-port ram, one write port, registered read port
//####################################################################
`timescale 1ns/1ns

module sdp_ram #(
    parameter type word_t = logic [7:0],
    parameter int DEPTH = 16
) (
    input  logic                     clk_sys,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  word_t                    wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output word_t                    rdata
);
    word_t mem [DEPTH];

    always_ff @(posedge clk_sys) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];  // old word on a same-address write
    end

endmodule

/* source/display_timing.sv */
//####################################################################
// raster counters with registered sync, data enable and line pulses
//####################################################################
`timescale 1ns/1ns
`include "video_defines.svh"

module display_timing (
    input logic clk_sys,
    input logic rst_n,
    video_timing_if.source tim
);
    // sync windows, counted from the start of the line or frame
    localparam int HS_START = `H_ACTIVE + `H_FP;  // 76
    localparam int HS_END = HS_START + `H_SYNC;   // first pixel after sync
    localparam int VS_START = `V_ACTIVE + `V_FP;  // 54
    localparam int VS_END = VS_START + `V_SYNC;

    video_pkg::coord_t nx;  // position one cycle ahead
    video_pkg::coord_t ny;

    // next position, wraps at the totals
    always_comb begin
        if (tim.sx == `H_TOTAL - 1) begin
            nx = '0;
            ny = (tim.sy == `V_TOTAL - 1) ? '0 : tim.sy + 1'b1;
        end else begin
            nx = tim.sx + 1'b1;
            ny = tim.sy;
        end
    end

    // flags decoded from the next position so they line up with sx/sy
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            tim.sx <= '0;
            tim.sy <= '0;
            // decode of position 0,0
            tim.hsync <= 1'b1;
            tim.vsync <= 1'b1;
            tim.de <= 1'b1;
            tim.line <= 1'b1;
            tim.frame <= 1'b1;
        end else begin
            tim.sx <= nx;
            tim.sy <= ny;
            tim.hsync <= !(nx >= HS_START && nx < HS_END);
            tim.vsync <= !(ny >= VS_START && ny < VS_END);
            tim.de <= (nx < `H_ACTIVE) && (ny < `V_ACTIVE);
            tim.line <= (nx == 0);
            tim.frame <= (nx == 0) && (ny == 0);
        end
    end

endmodule

/* source/scale_sequencer.sv */
//####################################################################
// row fetch scheduler: copies one framebuffer row into the idle
// line-buffer bank the line before that row goes on screen
//####################################################################
`timescale 1ns/1ns
`include "video_defines.svh"

module scale_sequencer (
    input  logic                clk_sys,
    input  logic                rst_n,
    video_timing_if.sink        tim,
    output video_pkg::fb_addr_t fb_raddr,
    input  video_pkg::cidx_t    fb_rdata,
    line_fill_if.filler         fill
);
    localparam int REP_W = $clog2(`FB_SCALE);
    localparam int ROW_W = $clog2(`FB_HEIGHT + 1);  // room for the idle value

    typedef enum logic {
        WAIT_LINE,
        FETCH
    } state_t;

    state_t state;

    logic [REP_W-1:0] rep_cnt;     // repeat of the current line's row
    logic [ROW_W-1:0] row_cnt;     // FB_HEIGHT when outside the picture
    logic [REP_W-1:0] coming_rep;  // same, for the line after this one
    logic [ROW_W-1:0] coming_row;
    logic             fetch_req;   // coming line starts a new row
    logic             row_start;   // current line starts a new row
    video_pkg::lb_addr_t fetch_col;
    video_pkg::lb_addr_t rd_col;   // column of the read in flight
    logic             rd_valid;

    // line counting, evaluated on the line pulse
    always_comb begin
        if (tim.sy == `V_TOTAL - 1) begin
            // last line of the frame, row 0 comes next
            coming_rep = '0;
            coming_row = '0;
        end else if (rep_cnt == `FB_SCALE - 1) begin
            coming_rep = '0;
            coming_row = (row_cnt < `FB_HEIGHT) ? row_cnt + 1'b1 : row_cnt;  // hold when idle
        end else begin
            coming_rep = rep_cnt + 1'b1;
            coming_row = row_cnt;
        end
        fetch_req = tim.line && (coming_rep == 0) && (coming_row < `FB_HEIGHT);
        row_start = (rep_cnt == 0) && (row_cnt < `FB_HEIGHT);
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            rep_cnt <= '0;
            row_cnt <= ROW_W'(`FB_HEIGHT);  // idle until line 57
            fill.show_bank <= 1'b0;
        end else if (tim.line) begin
            rep_cnt <= coming_rep;
            row_cnt <= coming_row;
            if (row_start) begin
                fill.show_bank <= ~fill.show_bank;  // freshly filled bank on screen
            end
        end
    end

    // one row of reads, 16 consecutive cycles
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            state <= WAIT_LINE;
            fb_raddr <= '0;
            fetch_col <= '0;
            rd_valid <= 1'b0;
            rd_col <= '0;
        end else begin
            rd_valid <= (state == FETCH);  // ram data arrives next cycle
            rd_col <= fetch_col;
            case (state)
                WAIT_LINE: begin
                    if (fetch_req) begin
                        state <= FETCH;
                        fb_raddr <= video_pkg::fb_addr_t'(coming_row * `FB_WIDTH);
                        fetch_col <= '0;
                    end
                end
                FETCH: begin
                    if (fetch_col == `FB_WIDTH - 1) begin
                        state <= WAIT_LINE;  // last word of the row
                    end else begin
                        fb_raddr <= fb_raddr + 1'b1;
                        fetch_col <= fetch_col + 1'b1;
                    end
                end
                default: state <= WAIT_LINE;
            endcase
        end
    end

    // write side, one cycle behind the read
    assign fill.we = rd_valid;
    assign fill.waddr = rd_col;
    assign fill.wdata = fb_rdata;
    assign fill.wbank = ~fill.show_bank;

endmodule

/* source/line_buffer.sv */
//####################################################################
// two-bank row store, each stored pixel read out FB_SCALE times
//####################################################################
`timescale 1ns/1ns
`include "video_defines.svh"

module line_buffer (
    input  logic             clk_sys,
    input  logic             rst_n,
    video_timing_if.sink     tim,
    line_fill_if.store       fill,
    output video_pkg::cidx_t cidx,
    output logic             in_picture
);
    logic [$clog2(`FB_SCALE)-1:0] hscale_cnt;  // pixel within one stored column
    video_pkg::lb_addr_t rd_col;
    video_pkg::cidx_t bank_rdata [2];

    // one ram per bank, both read every cycle
    for (genvar b = 0; b < 2; b++) begin : g_bank
        sdp_ram #(
            .word_t(video_pkg::cidx_t),
            .DEPTH(`FB_WIDTH)
        ) u_bank (
            .clk_sys(clk_sys),
            .we(fill.we && (fill.wbank == b)),
            .waddr(fill.waddr),
            .wdata(fill.wdata),
            .raddr(rd_col),
            .rdata(bank_rdata[b])
        );
    end

    // horizontal scaling
    // counter sits at 0 from sx 63 on, so column 0 is ready at sx 0
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            hscale_cnt <= '0;
            rd_col <= '0;
        end else if (tim.sx >= `PIC_WIDTH - 1) begin
            hscale_cnt <= '0;
            rd_col <= '0;
        end else if (hscale_cnt == `FB_SCALE - 1) begin
            hscale_cnt <= '0;
            rd_col <= rd_col + 1'b1;  // next stored pixel
        end else begin
            hscale_cnt <= hscale_cnt + 1'b1;
        end
    end

    // picture flag, one cycle like the ram read
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            in_picture <= 1'b0;
        end else begin
            in_picture <= (tim.sx < `PIC_WIDTH) && (tim.sy < `PIC_HEIGHT);
        end
    end

    // bank chosen after the read, show_bank has flipped by sx 0's data
    assign cidx = bank_rdata[fill.show_bank];

endmodule

/* source/colour_output.sv */
//####################################################################
// palette lookup, border and blanking, registered vga pins
//####################################################################
`timescale 1ns/1ns
`include "video_defines.svh"

module colour_output (
    input  logic             clk_sys,
    input  logic             rst_n,
    video_timing_if.sink     tim,
    input  video_pkg::cidx_t cidx,
    input  logic             in_picture,
    input  logic             pal_we,
    input  video_pkg::cidx_t pal_widx,
    input  video_pkg::rgb_t  pal_wdata,
    output logic             vga_hsync,
    output logic             vga_vsync,
    output logic [3:0]       vga_r,
    output logic [3:0]       vga_g,
    output logic [3:0]       vga_b
);
    localparam int PAL_DEPTH = 2 ** $bits(video_pkg::cidx_t);

    video_pkg::rgb_t pal_rgb;  // palette entry, 2 cycles after the position
    video_pkg::rgb_t pix;
    logic [1:0] hs_pipe;       // line-buffer and palette stages
    logic [1:0] vs_pipe;
    logic [1:0] de_pipe;
    logic pic_d;               // in_picture behind the palette read

    sdp_ram #(
        .word_t(video_pkg::rgb_t),
        .DEPTH(PAL_DEPTH)
    ) u_palette (
        .clk_sys(clk_sys),
        .we(pal_we),
        .waddr(pal_widx),
        .wdata(pal_wdata),
        .raddr(cidx),
        .rdata(pal_rgb)
    );

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            hs_pipe <= '1;  // syncs idle high
            vs_pipe <= '1;
            de_pipe <= '0;
            pic_d <= 1'b0;
        end else begin
            hs_pipe <= {hs_pipe[0], tim.hsync};
            vs_pipe <= {vs_pipe[0], tim.vsync};
            de_pipe <= {de_pipe[0], tim.de};
            pic_d <= in_picture;
        end
    end

    // picture, border or black
    always_comb begin
        if (!de_pipe[1]) begin
            pix = '0;
        end else if (pic_d) begin
            pix = pal_rgb;
        end else begin
            pix = video_pkg::rgb_t'(`BORDER_COLOUR);
        end
    end

    // pin registers, third stage
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_r <= '0;
            vga_g <= '0;
            vga_b <= '0;
        end else begin
            vga_hsync <= hs_pipe[1];
            vga_vsync <= vs_pipe[1];
            vga_r <= pix.r;
            vga_g <= pix.g;
            vga_b <= pix.b;
        end
    end

endmodule

/* source/video_top.sv */
//####################################################################
// scaled framebuffer video generator, top level
//####################################################################
`timescale 1ns/1ns
`include "video_defines.svh"

module video_top (
    input  logic                 clk_sys,
    input  logic                 rst_n,
    input  logic                 fb_we,
    input  logic [`FB_ADDRW-1:0] fb_waddr,
    input  logic [3:0]           fb_wdata,
    input  logic                 pal_we,
    input  logic [3:0]           pal_widx,
    input  logic [11:0]          pal_wdata,
    output logic                 vga_hsync,
    output logic                 vga_vsync,
    output logic [3:0]           vga_r,
    output logic [3:0]           vga_g,
    output logic [3:0]           vga_b
);
    video_pkg::fb_addr_t fb_raddr;
    video_pkg::cidx_t fb_rdata;
    video_pkg::cidx_t lb_cidx;  // line-buffer pixel, 1 cycle behind sx
    logic lb_in_picture;

    video_timing_if tim ();
    line_fill_if fill ();

    display_timing u_timing (
        .clk_sys(clk_sys),
        .rst_n(rst_n),
        .tim(tim)
    );

    // framebuffer, host writes and row fetch reads
    sdp_ram #(
        .word_t(video_pkg::cidx_t),
        .DEPTH(`FB_PIXELS)
    ) u_framebuffer (
        .clk_sys(clk_sys),
        .we(fb_we),
        .waddr(fb_waddr),
        .wdata(fb_wdata),
        .raddr(fb_raddr),
        .rdata(fb_rdata)
    );

    scale_sequencer u_sequencer (
        .clk_sys(clk_sys),
        .rst_n(rst_n),
        .tim(tim),
        .fb_raddr(fb_raddr),
        .fb_rdata(fb_rdata),
        .fill(fill)
    );

    line_buffer u_line_buffer (
        .clk_sys(clk_sys),
        .rst_n(rst_n),
        .tim(tim),
        .fill(fill),
        .cidx(lb_cidx),
        .in_picture(lb_in_picture)
    );

    colour_output u_colour (
        .clk_sys(clk_sys),
        .rst_n(rst_n),
        .tim(tim),
        .cidx(lb_cidx),
        .in_picture(lb_in_picture),
        .pal_we(pal_we),
        .pal_widx(pal_widx),
        .pal_wdata(pal_wdata),
        .vga_hsync(vga_hsync),
        .vga_vsync(vga_vsync),
        .vga_r(vga_r),
        .vga_g(vga_g),
        .vga_b(vga_b)
    );

endmodule

/* tb/video_tb.sv */
//####################################################################
// testbench for the scaled framebuffer video generator
// every pin compared against a raster model fed with random images and palettes
//####################################################################
`timescale 1ns/1ns
`include "video_defines.svh"

module video_tb;
    localparam int FRAME = `H_TOTAL * `V_TOTAL;  // cycles per frame
    localparam int RUN_CYCLES = 3 + 5 * FRAME;   // pin latency plus frames 0..4
    localparam int LIMIT = 7 * FRAME + 5;        // 7 frames plus reset
    localparam int HS_START = `H_ACTIVE + `H_FP;
    localparam int VS_START = `V_ACTIVE + `V_FP;

    logic clk_sys;
    logic rst_n;
    logic fb_we;
    logic [`FB_ADDRW-1:0] fb_waddr;
    logic [3:0] fb_wdata;
    logic pal_we;
    logic [3:0] pal_widx;
    logic [11:0] pal_wdata;
    logic vga_hsync;
    logic vga_vsync;
    logic [3:0] vga_r;
    logic [3:0] vga_g;
    logic [3:0] vga_b;

    logic [3:0] fb_model [`FB_PIXELS];  // image as the DUT holds it
    logic [11:0] pal_model [16];
    logic [31:0] lcg_state = 32'h3358;
    int errs [5];  // per test
    int checks;
    int cycles;
    string names [5] = '{"sync timing", "scaled image", "border and blanking",
                         "image update", "palette update"};

    video_top DUT (.*);

    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;
    end

    // watchdog
    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk_sys);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", LIMIT);
        $display("Verification failed");
        $finish;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // colour expected at the pins for raster position x,y
    function automatic logic [11:0] expected_rgb(input int x, input int y);
        if (x >= `H_ACTIVE || y >= `V_ACTIVE) return 12'h000;  // blanking
        if (x >= `PIC_WIDTH || y >= `PIC_HEIGHT) return `BORDER_COLOUR;
        return pal_model[fb_model[(y / `FB_SCALE) * `FB_WIDTH + x / `FB_SCALE]];
    endfunction

    task automatic check_value(input int test, input string what, input logic [11:0] got,
                               input logic [11:0] exp, input int x, input int y);
        checks++;
        if (got !== exp) begin
            errs[test]++;
            $display("Fail at %0t ns: %s at %0d,%0d is %h, expected %h",
                     $time, what, x, y, got, exp);
        end
    endtask

    task automatic report_test(input int n);
        $display("test %0d %s: %s (%0d errors)", n + 1, names[n],
                 (errs[n] == 0) ? "ok" : "errors seen", errs[n]);
    endtask

    // host writes for frame f
    // k counts cycles from the start of line 52 and is -1 outside
    task automatic drive_writes(input int f, input int k);
        logic [31:0] r;
        int idx;
        r = next_random();
        fb_we = 1'b0;
        pal_we = 1'b0;
        if ((f == 1 || f == 2) && k >= 0 && k < `FB_PIXELS) begin
            fb_we = 1'b1;  // new image in frames 1 and 2
            fb_waddr = k[`FB_ADDRW-1:0];
            fb_wdata = r[19:16];
            fb_model[k] = r[19:16];
        end else if ((f == 1 && k >= `FB_PIXELS && k < `FB_PIXELS + 16) ||
                     (f == 3 && k >= 0 && k < 16)) begin
            idx = (f == 1) ? k - `FB_PIXELS : k;  // palette after the image
            pal_we = 1'b1;
            pal_widx = idx[3:0];
            pal_wdata = r[27:16];
            pal_model[idx] = r[27:16];
        end
    endtask

    initial begin
        int c;
        int p;
        int px;
        int py;
        int pf;
        int dy;
        int total;
        rst_n = 1'b0;
        fb_we = 1'b0;
        fb_waddr = '0;
        fb_wdata = '0;
        pal_we = 1'b0;
        pal_widx = '0;
        pal_wdata = '0;
        checks = 0;
        foreach (errs[i]) errs[i] = 0;
        repeat (5) @(posedge clk_sys);
        #1 rst_n = 1'b1;
        for (c = 0; c < RUN_CYCLES; c++) begin
            if (c < 3) begin
                // pipeline still holds its reset state
                check_value(0, "hsync after reset", vga_hsync, 12'h001, 0, 0);
                check_value(0, "vsync after reset", vga_vsync, 12'h001, 0, 0);
                check_value(2, "colour after reset", {vga_r, vga_g, vga_b}, 12'h000, 0, 0);
            end else begin
                p = c - 3;  // position now at the pins
                px = p % `H_TOTAL;
                py = (p / `H_TOTAL) % `V_TOTAL;
                pf = p / FRAME;
                check_value(0, "hsync", vga_hsync, !(px >= HS_START && px < HS_START + `H_SYNC),
                            px, py);
                check_value(0, "vsync", vga_vsync, !(py >= VS_START && py < VS_START + `V_SYNC),
                            px, py);
                if (px < `PIC_WIDTH && py < `PIC_HEIGHT) begin
                    if (pf >= 2) begin  // frames 0 and 1 show an unloaded image
                        check_value((pf == 2) ? 1 : (pf == 3) ? 3 : 4, "pixel",
                                    {vga_r, vga_g, vga_b}, expected_rgb(px, py), px, py);
                    end
                end else begin
                    check_value(2, "border/blank", {vga_r, vga_g, vga_b}, expected_rgb(px, py),
                                px, py);
                end
                if (p % FRAME == FRAME - 1 && pf >= 2) begin
                    report_test((pf == 2) ? 1 : (pf == 3) ? 3 : 4);
                end
            end
            dy = (c / `H_TOTAL) % `V_TOTAL;  // line the DUT is on
            if (dy >= `V_ACTIVE && dy < `V_ACTIVE + 5) begin
                drive_writes(c / FRAME, (dy - `V_ACTIVE) * `H_TOTAL + c % `H_TOTAL);
            end else begin
                drive_writes(c / FRAME, -1);
            end
            @(posedge clk_sys);
            #1;
        end
        report_test(0);
        report_test(2);
        total = errs[0] + errs[1] + errs[2] + errs[3] + errs[4];
        $display("%0d checks, %0d errors", checks, total);
        if (total == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+source
source/video_pkg.sv
source/video_timing_if.sv
source/sdp_ram.sv
source/display_timing.sv
source/scale_sequencer.sv
source/line_buffer.sv
source/colour_output.sv
source/video_top.sv
tb/video_tb.sv

/* Bender.yml */
package:
  name: video_gen

sources:
  - include_dirs:
      - source
    files:
      - source/video_pkg.sv
      - source/video_timing_if.sv
      - source/sdp_ram.sv
      - source/display_timing.sv
      - source/scale_sequencer.sv
      - source/line_buffer.sv
      - source/colour_output.sv
      - source/video_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/video_tb.sv
